// ==== source/fpu_macros.svh ====
`ifndef FPU_MACROS_SVH
`define FPU_MACROS_SVH

// Datapath and register file sizes
`define FPU_XLEN  32
`define FPU_NREGS 32

// CSR addresses
`define FPU_CSR_FFLAGS 12'h001
`define FPU_CSR_FRM    12'h002
`define FPU_CSR_FCSR   12'h003

`define FPU_CANON_NAN 32'h7FC00000

`endif

// ==== source/fpu_pkg.sv ====
`include "fpu_macros.svh"

package fpu_pkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Encodings
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  typedef enum logic [6:0] {
    OPC_OP_FP = 7'b1010011
  } fp_opcode_e;

  typedef enum logic [3:0] {
    OP_NONE,
    OP_FSGNJ,
    OP_FSGNJN,
    OP_FSGNJX,
    OP_FMIN,
    OP_FMAX,
    OP_FEQ,
    OP_FLT,
    OP_FLE,
    OP_FCLASS,
    OP_FMV_X_W,
    OP_FMV_W_X
  } fp_op_e;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Stage structs
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  typedef struct packed {
    fp_op_e     op;
    logic [4:0] rd;
    logic [4:0] rs1;
    logic [4:0] rs2;
    logic       fwren;   // Writes an f register
    logic       wren;    // Integer result
    logic       frden1;
    logic       frden2;
    logic       valid;
  } fp_decode_t;

  typedef struct packed {
    logic                 wren;
    logic [4:0]           waddr;
    logic [`FPU_XLEN-1:0] wdata;
  } fp_fwd_src_t;

  typedef struct packed {
    logic                 valid;
    logic                 fwren;
    logic                 wren;
    logic [4:0]           rd;
    logic [`FPU_XLEN-1:0] data;
    logic                 fpu;     // Accrue fflags
    logic [4:0]           fflags;  // NV DZ OF UF NX
  } fp_result_t;

  typedef struct packed {
    logic                 cwren;
    logic [11:0]          cwaddr;
    logic [`FPU_XLEN-1:0] cdata;
  } fp_csr_write_t;

endpackage

// ==== source/fpu_decode.sv ====
`timescale 1ns/1ps

module fpu_decode (
  input  logic [31:0]         instr_i,
  output fpu_pkg::fp_decode_t decode_o
);
  import fpu_pkg::*;

  logic [6:0] opcode;
  logic [6:0] funct7;
  logic [2:0] funct3;
  logic [4:0] rs2;
  fp_decode_t dec;

  assign opcode = instr_i[6:0];
  assign funct3 = instr_i[14:12];
  assign rs2    = instr_i[24:20];
  assign funct7 = instr_i[31:25];

  always_comb begin
    dec     = '0;
    dec.op  = OP_NONE;
    dec.rd  = instr_i[11:7];
    dec.rs1 = instr_i[19:15];
    dec.rs2 = rs2;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Operation select
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    if (opcode == OPC_OP_FP) begin
      case (funct7)
        7'b0010000: begin  // Sign injection
          case (funct3)
            3'b000:  dec.op = OP_FSGNJ;
            3'b001:  dec.op = OP_FSGNJN;
            3'b010:  dec.op = OP_FSGNJX;
            default: dec.op = OP_NONE;
          endcase
        end
        7'b0010100: begin
          case (funct3)
            3'b000:  dec.op = OP_FMIN;
            3'b001:  dec.op = OP_FMAX;
            default: dec.op = OP_NONE;
          endcase
        end
        7'b1010000: begin
          case (funct3)
            3'b010:  dec.op = OP_FEQ;
            3'b001:  dec.op = OP_FLT;
            3'b000:  dec.op = OP_FLE;
            default: dec.op = OP_NONE;
          endcase
        end
        7'b1110000: begin
          if (rs2 == 5'd0 && funct3 == 3'b000) dec.op = OP_FMV_X_W;
          if (rs2 == 5'd0 && funct3 == 3'b001) dec.op = OP_FCLASS;
        end
        7'b1111000: begin
          if (rs2 == 5'd0 && funct3 == 3'b000) dec.op = OP_FMV_W_X;
        end
        default: dec.op = OP_NONE;  // Arithmetic and conversions too
      endcase
    end

    // Enables follow from the operation
    case (dec.op)
      OP_FSGNJ, OP_FSGNJN, OP_FSGNJX, OP_FMIN, OP_FMAX: begin
        dec.fwren  = 1'b1;
        dec.frden1 = 1'b1;
        dec.frden2 = 1'b1;
      end
      OP_FEQ, OP_FLT, OP_FLE: begin
        dec.wren   = 1'b1;
        dec.frden1 = 1'b1;
        dec.frden2 = 1'b1;
      end
      OP_FCLASS, OP_FMV_X_W: begin
        dec.wren   = 1'b1;
        dec.frden1 = 1'b1;
      end
      OP_FMV_W_X: dec.fwren = 1'b1;  // Source is int_data
      default: ;
    endcase

    dec.valid = (dec.op != OP_NONE);
  end

  assign decode_o = dec;

endmodule

// ==== source/fpu_register.sv ====
`timescale 1ns/1ps
`include "fpu_macros.svh"

module fpu_register (
  input  logic                  clock,
  input  logic                  reset,
  input  logic [4:0]            raddr1_i,
  input  logic [4:0]            raddr2_i,
  input  fpu_pkg::fp_fwd_src_t  write_i,
  output logic [`FPU_XLEN-1:0]  rdata1_o,
  output logic [`FPU_XLEN-1:0]  rdata2_o
);
  logic [`FPU_XLEN-1:0] regs [0:`FPU_NREGS-1] = '{default: '0};
  logic [4:0]           raddr1_q;
  logic [4:0]           raddr2_q;

  always_ff @(posedge clock) begin
    if (reset) begin
      raddr1_q <= 5'd0;
      raddr2_q <= 5'd0;
    end else begin
      raddr1_q <= raddr1_i;
      raddr2_q <= raddr2_i;
    end
    if (write_i.wren) regs[write_i.waddr] <= write_i.wdata;
  end

  // Write and address update share an edge, so reads see new data
  assign rdata1_o = regs[raddr1_q];
  assign rdata2_o = regs[raddr2_q];

endmodule

// ==== source/fpu_forwarding.sv ====
`timescale 1ns/1ps
`include "fpu_macros.svh"

module fpu_forwarding (
  input  logic                  rden1_i,
  input  logic                  rden2_i,
  input  logic [4:0]            raddr1_i,
  input  logic [4:0]            raddr2_i,
  input  logic [`FPU_XLEN-1:0]  rdata1_i,
  input  logic [`FPU_XLEN-1:0]  rdata2_i,
  input  fpu_pkg::fp_fwd_src_t  mem_i,
  input  fpu_pkg::fp_fwd_src_t  wb_i,
  output logic [`FPU_XLEN-1:0]  data1_o,
  output logic [`FPU_XLEN-1:0]  data2_o
);
  import fpu_pkg::*;

  function automatic logic [`FPU_XLEN-1:0] pick(
    input logic                 rden,
    input logic [4:0]           raddr,
    input logic [`FPU_XLEN-1:0] rdata,
    input fp_fwd_src_t          mem,
    input fp_fwd_src_t          wb
  );
    logic [`FPU_XLEN-1:0] res;
    res = '0;
    if (rden) begin
      // Youngest producer wins
      if (mem.wren && mem.waddr == raddr) begin
        res = mem.wdata;
      end else if (wb.wren && wb.waddr == raddr) begin
        res = wb.wdata;
      end else begin
        res = rdata;
      end
    end
    return res;
  endfunction

  assign data1_o = pick(rden1_i, raddr1_i, rdata1_i, mem_i, wb_i);
  assign data2_o = pick(rden2_i, raddr2_i, rdata2_i, mem_i, wb_i);

endmodule

// ==== source/fpu_csr.sv ====
`timescale 1ns/1ps
`include "fpu_macros.svh"

module fpu_csr (
  input  logic                   clock,
  input  logic                   reset,
  input  fpu_pkg::fp_csr_write_t csr_wr_i,
  input  logic                   csr_rden_i,
  input  logic [11:0]            csr_raddr_i,
  input  fpu_pkg::fp_result_t    accrue_i,
  output logic [`FPU_XLEN-1:0]   csr_rdata_o,
  output logic                   csr_ready_o
);
  import fpu_pkg::*;

  logic [2:0] frm;
  logic [4:0] fflags;
  logic [2:0] frm_next;
  logic [4:0] fflags_next;
  logic       accrue;

  assign accrue = accrue_i.valid && accrue_i.fpu;

  always_comb begin
    frm_next    = frm;
    fflags_next = fflags;
    if (csr_wr_i.cwren) begin
      case (csr_wr_i.cwaddr)
        `FPU_CSR_FFLAGS: fflags_next = csr_wr_i.cdata[4:0];
        `FPU_CSR_FRM:    frm_next = csr_wr_i.cdata[2:0];
        `FPU_CSR_FCSR: begin
          fflags_next = csr_wr_i.cdata[4:0];
          frm_next    = csr_wr_i.cdata[7:5];
        end
        default: ;
      endcase
    end
    if (accrue) fflags_next = fflags_next | accrue_i.fflags;  // Sticky on top of write
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      frm    <= 3'd0;
      fflags <= 5'd0;
    end else begin
      frm    <= frm_next;
      fflags <= fflags_next;
    end
  end

  always_comb begin
    csr_rdata_o = '0;
    csr_ready_o = 1'b0;
    if (csr_rden_i) begin
      csr_ready_o = 1'b1;
      case (csr_raddr_i)
        `FPU_CSR_FFLAGS: csr_rdata_o = {27'd0, fflags};
        `FPU_CSR_FRM:    csr_rdata_o = {29'd0, frm};
        `FPU_CSR_FCSR:   csr_rdata_o = {24'd0, frm, fflags};
        default:         csr_ready_o = 1'b0;
      endcase
    end
  end

  // Flag updates only arrive with a valid result
  a_no_stray_accrue: assert property (@(posedge clock) disable iff (reset)
    accrue_i.fpu |-> accrue_i.valid);

endmodule

// ==== source/fpu_execute.sv ====
`timescale 1ns/1ps
`include "fpu_macros.svh"

module fpu_execute (
  input  fpu_pkg::fp_decode_t  op_data_i,
  input  logic                 valid_i,
  input  logic [`FPU_XLEN-1:0] data1_i,
  input  logic [`FPU_XLEN-1:0] data2_i,
  input  logic [`FPU_XLEN-1:0] int_data_i,
  output fpu_pkg::fp_result_t  result_o
);
  import fpu_pkg::*;

  // One-hot RISC-V class, bit 8 sNaN, bit 9 qNaN
  function automatic logic [9:0] fp_class(input logic [31:0] x);
    logic       sgn;
    logic [7:0] exp;
    logic [22:0] man;
    logic [9:0] cls;
    sgn = x[31];
    exp = x[30:23];
    man = x[22:0];
    cls = '0;
    if (&exp) begin
      if (man == '0) cls[sgn ? 0 : 7] = 1'b1;
      else if (man[22]) cls[9] = 1'b1;
      else cls[8] = 1'b1;
    end else if (exp == '0) begin
      if (man == '0) cls[sgn ? 3 : 4] = 1'b1;
      else cls[sgn ? 2 : 5] = 1'b1;
    end else begin
      cls[sgn ? 1 : 6] = 1'b1;
    end
    return cls;
  endfunction

  logic [9:0]           cls1;
  logic [9:0]           cls2;
  logic                 nan1;
  logic                 nan2;
  logic                 snan;
  logic                 both_zero;
  logic                 lt_raw;  // Total order, -0 below +0
  logic                 feq;
  logic                 flt;
  logic [`FPU_XLEN-1:0] res;
  logic                 nv;
  logic                 upd_flags;

  assign cls1      = fp_class(data1_i);
  assign cls2      = fp_class(data2_i);
  assign nan1      = cls1[8] | cls1[9];
  assign nan2      = cls2[8] | cls2[9];
  assign snan      = cls1[8] | cls2[8];
  assign both_zero = (data1_i[30:0] == '0) && (data2_i[30:0] == '0);

  always_comb begin
    if (data1_i[31] != data2_i[31]) lt_raw = data1_i[31];
    else if (!data1_i[31]) lt_raw = data1_i[30:0] < data2_i[30:0];
    else lt_raw = data1_i[30:0] > data2_i[30:0];
  end

  assign feq = !nan1 && !nan2 && ((data1_i == data2_i) || both_zero);
  assign flt = !nan1 && !nan2 && lt_raw && !both_zero;

  always_comb begin
    res       = '0;
    nv        = 1'b0;
    upd_flags = 1'b0;
    case (op_data_i.op)
      OP_FSGNJ:  res = {data2_i[31], data1_i[30:0]};
      OP_FSGNJN: res = {~data2_i[31], data1_i[30:0]};
      OP_FSGNJX: res = {data1_i[31] ^ data2_i[31], data1_i[30:0]};
      OP_FMIN, OP_FMAX: begin
        upd_flags = 1'b1;
        nv        = snan;
        if (nan1 && nan2) res = `FPU_CANON_NAN;
        else if (nan1) res = data2_i;
        else if (nan2) res = data1_i;
        else if (op_data_i.op == OP_FMIN) res = lt_raw ? data1_i : data2_i;
        else res = lt_raw ? data2_i : data1_i;
      end
      OP_FEQ: begin
        upd_flags = 1'b1;
        nv        = snan;
        res       = {31'd0, feq};
      end
      OP_FLT, OP_FLE: begin
        upd_flags = 1'b1;
        nv        = nan1 | nan2;  // Signaling compares
        res       = {31'd0, flt | (op_data_i.op == OP_FLE && feq)};
      end
      OP_FCLASS:  res = {22'd0, cls1};
      OP_FMV_X_W: res = data1_i;
      OP_FMV_W_X: res = int_data_i;
      default: ;
    endcase
  end

  assign result_o.valid  = valid_i;
  assign result_o.fwren  = valid_i & op_data_i.fwren;
  assign result_o.wren   = valid_i & op_data_i.wren;
  assign result_o.rd     = op_data_i.rd;
  assign result_o.data   = res;
  assign result_o.fpu    = valid_i & upd_flags;
  assign result_o.fflags = {nv, 4'b0000};

  // Decoder must never ask for both destinations
  always_comb begin
    if (valid_i) assert (!(result_o.fwren && result_o.wren));
  end

endmodule

// ==== source/fpu_top.sv ====
`timescale 1ns/1ps
`include "fpu_macros.svh"

module fpu_top (
  input  logic                   clock,
  input  logic                   reset,
  input  logic                   instr_valid_i,
  input  logic [31:0]            instr_i,
  input  logic [31:0]            int_data_i,
  input  fpu_pkg::fp_csr_write_t csr_wr_i,
  input  logic                   csr_rden_i,
  input  logic [11:0]            csr_raddr_i,
  output logic [`FPU_XLEN-1:0]   csr_rdata_o,
  output logic                   csr_ready_o,
  output fpu_pkg::fp_result_t    wb_o,
  output logic                   illegal_o
);
  import fpu_pkg::*;

  fp_decode_t           dec;
  fp_decode_t           iss_dec;   // Issue stage payload
  logic [31:0]          iss_int;
  logic                 iss_valid;
  logic                 illegal_q;
  fp_result_t           ex_res;
  fp_result_t           ex_q;      // Execute-output stage
  fp_result_t           wb_q;
  fp_fwd_src_t          mem_src;
  fp_fwd_src_t          wb_src;
  logic [`FPU_XLEN-1:0] rdata1;
  logic [`FPU_XLEN-1:0] rdata2;
  logic [`FPU_XLEN-1:0] op1;
  logic [`FPU_XLEN-1:0] op2;

  fpu_decode fpu_decode_inst (.instr_i(instr_i), .decode_o(dec));

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Pipeline registers
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_ff @(posedge clock) begin
    iss_dec <= dec;
    iss_int <= int_data_i;
    ex_q    <= ex_res;
    wb_q    <= ex_q;
    if (reset) begin
      iss_valid  <= 1'b0;
      illegal_q  <= 1'b0;
      ex_q.valid <= 1'b0;
      wb_q.valid <= 1'b0;
    end else begin
      iss_valid <= instr_valid_i & dec.valid;
      illegal_q <= instr_valid_i & ~dec.valid;
    end
  end

  assign mem_src = '{wren: ex_q.valid & ex_q.fwren, waddr: ex_q.rd, wdata: ex_q.data};
  assign wb_src  = '{wren: wb_q.valid & wb_q.fwren, waddr: wb_q.rd, wdata: wb_q.data};

  fpu_register fpu_register_inst (
    .clock    (clock),
    .reset    (reset),
    .raddr1_i (dec.rs1),  // Latched on the issue edge
    .raddr2_i (dec.rs2),
    .write_i  (wb_src),
    .rdata1_o (rdata1),
    .rdata2_o (rdata2)
  );

  fpu_forwarding fpu_forwarding_inst (
    .rden1_i  (iss_dec.frden1),
    .rden2_i  (iss_dec.frden2),
    .raddr1_i (iss_dec.rs1),
    .raddr2_i (iss_dec.rs2),
    .rdata1_i (rdata1),
    .rdata2_i (rdata2),
    .mem_i    (mem_src),
    .wb_i     (wb_src),
    .data1_o  (op1),
    .data2_o  (op2)
  );

  fpu_execute fpu_execute_inst (
    .op_data_i  (iss_dec),
    .valid_i    (iss_valid),
    .data1_i    (op1),
    .data2_i    (op2),
    .int_data_i (iss_int),
    .result_o   (ex_res)
  );

  fpu_csr fpu_csr_inst (
    .clock       (clock),
    .reset       (reset),
    .csr_wr_i    (csr_wr_i),
    .csr_rden_i  (csr_rden_i),
    .csr_raddr_i (csr_raddr_i),
    .accrue_i    (wb_q),
    .csr_rdata_o (csr_rdata_o),
    .csr_ready_o (csr_ready_o)
  );

  assign wb_o      = wb_q;
  assign illegal_o = illegal_q;

  // An illegal instruction leaves its own writeback slot empty
  a_illegal_no_wb: assert property (@(posedge clock) disable iff (reset)
    wb_o.valid |-> !$past(illegal_o, 2));

endmodule

// ==== dv/fpu_tb.sv ====
`timescale 1ns/1ps
`include "fpu_macros.svh"

module fpu_tb;
  import fpu_pkg::*;

  logic          clock;
  logic          reset;
  logic          instr_valid_i;
  logic [31:0]   instr_i;
  logic [31:0]   int_data_i;
  fp_csr_write_t csr_wr_i;
  logic          csr_rden_i;
  logic [11:0]   csr_raddr_i;
  logic [31:0]   csr_rdata_o;
  logic          csr_ready_o;
  fp_result_t    wb_o;
  logic          illegal_o;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Reference model state
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  logic [31:0] shadow [0:`FPU_NREGS-1];
  logic [4:0]  model_fflags;
  logic [2:0]  model_frm;
  fp_result_t  exp_next;
  fp_result_t  exp_iss;
  fp_result_t  exp_ex;
  fp_result_t  exp_wb;
  logic        ill_next;
  logic        exp_ill;
  logic        csr_chk;
  logic        exp_ready;
  logic [31:0] exp_csr;
  int          cycles = 0;
  int          issued = 0;
  string       test_name = "reset";

  // Operand pairs {a, b}: ordered, signed zeros, quiet and signaling NaNs
  logic [63:0] special_pairs [0:11] = '{
    64'h3F800000_40000000, 64'hC0400000_3F800000, 64'h80000000_00000000,
    64'h00000000_80000000, 64'h7FC00001_3F800000, 64'hC0400000_7F800001,
    64'h7FC00000_7F800001, 64'hFFC00000_7FC12345, 64'h3F800000_3F800000,
    64'h00000001_FF800000, 64'h7F800001_807FFFFF, 64'h7F800000_807FFFFF
  };

  fpu_top fpu_top_inst (
    .clock         (clock),
    .reset         (reset),
    .instr_valid_i (instr_valid_i),
    .instr_i       (instr_i),
    .int_data_i    (int_data_i),
    .csr_wr_i      (csr_wr_i),
    .csr_rden_i    (csr_rden_i),
    .csr_raddr_i   (csr_raddr_i),
    .csr_rdata_o   (csr_rdata_o),
    .csr_ready_o   (csr_ready_o),
    .wb_o          (wb_o),
    .illegal_o     (illegal_o)
  );

  initial begin
    clock = 1'b0;
    forever #10 clock = ~clock;
  end

  // Expected results follow the DUT pipeline, issue to writeback
  always @(posedge clock) begin
    exp_iss <= exp_next;
    exp_ex  <= exp_iss;
    exp_wb  <= exp_ex;
    exp_ill <= ill_next;
    cycles  <= cycles + 1;
    if (cycles > 4 * issued + 200) begin
      $display("Timeout: %0d cycles passed with %0d instructions issued", cycles, issued);
      $display("=== FAIL ===");
      $fatal(1, "simulation timed out");
    end
  end

  task automatic report_mismatch(input string what, input logic [63:0] expected,
                                 input logic [63:0] actual);
    $display("[FAIL] %s %s expected %h actual %h", test_name, what, expected, actual);
    $display("=== FAIL ===");
    $fatal(1, "%s mismatch", what);
  endtask

  wb_matches: assert property (@(posedge clock) disable iff (reset)
    (wb_o.valid == exp_wb.valid) && (!exp_wb.valid || wb_o == exp_wb))
    else report_mismatch("wb_o", 64'($sampled(exp_wb)), 64'($sampled(wb_o)));

  illegal_matches: assert property (@(posedge clock) disable iff (reset)
    illegal_o == exp_ill)
    else report_mismatch("illegal_o", 64'($sampled(exp_ill)), 64'($sampled(illegal_o)));

  csr_matches: assert property (@(posedge clock) disable iff (reset)
    !csr_chk || (csr_ready_o == exp_ready && csr_rdata_o == exp_csr))
    else report_mismatch("csr {ready, data}", 64'({$sampled(exp_ready), $sampled(exp_csr)}),
                         64'({$sampled(csr_ready_o), $sampled(csr_rdata_o)}));

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Single-precision rules
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  function automatic logic is_nan(input logic [31:0] x);
    return (x[30:23] == 8'hff) && (x[22:0] != 23'd0);
  endfunction

  function automatic logic is_snan(input logic [31:0] x);
    return is_nan(x) && !x[22];
  endfunction

  // Unsigned sort key, -0 just below +0
  function automatic logic [31:0] order_key(input logic [31:0] x);
    return x[31] ? ~x : {1'b1, x[30:0]};
  endfunction

  function automatic logic [9:0] classify(input logic [31:0] x);
    int idx;
    if (is_nan(x)) idx = x[22] ? 9 : 8;
    else if (x[30:23] == 8'hff) idx = x[31] ? 0 : 7;
    else if (x[30:0] == 31'd0) idx = x[31] ? 3 : 4;
    else if (x[30:23] == 8'h00) idx = x[31] ? 2 : 5;  // Subnormal
    else idx = x[31] ? 1 : 6;
    return 10'b1 << idx;
  endfunction

  task automatic compute(input fp_op_e op, input logic [31:0] a, input logic [31:0] b,
                         input logic [31:0] ival, output logic [31:0] data, output logic nv);
    logic nan_any;
    logic zeros;
    logic eq;
    logic lt;
    nan_any = is_nan(a) || is_nan(b);
    zeros   = ((a | b) & 32'h7fffffff) == 32'd0;
    eq      = !nan_any && (a == b || zeros);
    lt      = !nan_any && !zeros && (order_key(a) < order_key(b));
    data    = a;
    nv      = 1'b0;
    case (op)
      OP_FSGNJ:  data[31] = b[31];
      OP_FSGNJN: data[31] = ~b[31];
      OP_FSGNJX: data[31] = a[31] ^ b[31];
      OP_FMIN, OP_FMAX: begin
        nv = is_snan(a) || is_snan(b);
        if (is_nan(a) && is_nan(b)) data = `FPU_CANON_NAN;
        else if (is_nan(a)) data = b;
        else if (is_nan(b)) data = a;
        else if ((order_key(a) < order_key(b)) == (op == OP_FMIN)) data = a;
        else data = b;
      end
      OP_FEQ: begin
        nv   = is_snan(a) || is_snan(b);
        data = {31'd0, eq};
      end
      OP_FLT: begin
        nv   = nan_any;
        data = {31'd0, lt};
      end
      OP_FLE: begin
        nv   = nan_any;
        data = {31'd0, lt || eq};
      end
      OP_FCLASS:  data = {22'd0, classify(a)};
      OP_FMV_W_X: data = ival;
      default: ;  // FMV.X.W keeps a
    endcase
  endtask

  function automatic logic [31:0] encode(input fp_op_e op, input logic [4:0] rd,
                                         input logic [4:0] rs1, input logic [4:0] rs2);
    logic [6:0] f7;
    logic [2:0] f3;
    logic [4:0] r2;
    r2 = rs2;
    case (op)
      OP_FSGNJ, OP_FSGNJN, OP_FSGNJX: f7 = 7'b0010000;
      OP_FMIN, OP_FMAX:               f7 = 7'b0010100;
      OP_FEQ, OP_FLT, OP_FLE:         f7 = 7'b1010000;
      OP_FMV_W_X:                     f7 = 7'b1111000;
      default:                        f7 = 7'b1110000;
    endcase
    case (op)
      OP_FSGNJN, OP_FMAX, OP_FLT, OP_FCLASS: f3 = 3'b001;
      OP_FSGNJX, OP_FEQ:                    f3 = 3'b010;
      default:                              f3 = 3'b000;
    endcase
    if (op inside {OP_FCLASS, OP_FMV_X_W, OP_FMV_W_X}) r2 = 5'd0;
    return {f7, r2, rs1, f3, rd, 7'b1010011};
  endfunction

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Stimulus
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  task automatic next_cycle();
    @(negedge clock);
    instr_valid_i = 1'b0;
    instr_i       = 32'd0;
    int_data_i    = $urandom;
    exp_next      = '0;
    ill_next      = 1'b0;
    csr_wr_i      = '0;
    csr_rden_i    = 1'b0;
    csr_raddr_i   = 12'd0;
    csr_chk       = 1'b0;
  endtask

  task automatic idle(input int n);
    repeat (n) next_cycle();
  endtask

  task automatic issue(input fp_op_e op, input logic [4:0] rd, input logic [4:0] rs1,
                       input logic [4:0] rs2, input logic [31:0] ival);
    logic [31:0] data;
    logic        nv;
    logic        fw;
    next_cycle();
    instr_valid_i = 1'b1;
    instr_i       = encode(op, rd, rs1, rs2);
    int_data_i    = ival;
    compute(op, shadow[rs1], shadow[rs2], ival, data, nv);
    fw = op inside {OP_FSGNJ, OP_FSGNJN, OP_FSGNJX, OP_FMIN, OP_FMAX, OP_FMV_W_X};
    exp_next.valid  = 1'b1;
    exp_next.fwren  = fw;
    exp_next.wren   = !fw;
    exp_next.rd     = rd;
    exp_next.data   = data;
    exp_next.fpu    = op inside {OP_FMIN, OP_FMAX, OP_FEQ, OP_FLT, OP_FLE};
    exp_next.fflags = {nv, 4'b0000};
    if (fw) shadow[rd] = data;
    model_fflags = model_fflags | exp_next.fflags;
    issued++;
  endtask

  task automatic issue_illegal(input logic [31:0] word);
    next_cycle();
    instr_valid_i = 1'b1;
    instr_i       = word;
    ill_next      = 1'b1;  // No writeback expected
    issued++;
  endtask

  task automatic csr_write(input logic [11:0] addr, input logic [31:0] data);
    next_cycle();
    csr_wr_i = '{cwren: 1'b1, cwaddr: addr, cdata: data};
    case (addr)
      `FPU_CSR_FFLAGS: model_fflags = data[4:0];
      `FPU_CSR_FRM:    model_frm = data[2:0];
      `FPU_CSR_FCSR: begin
        model_frm    = data[7:5];
        model_fflags = data[4:0];
      end
      default: ;
    endcase
  endtask

  task automatic csr_read(input logic [11:0] addr);
    next_cycle();
    csr_rden_i  = 1'b1;
    csr_raddr_i = addr;
    csr_chk     = 1'b1;
    exp_ready   = 1'b1;
    case (addr)
      `FPU_CSR_FFLAGS: exp_csr = {27'd0, model_fflags};
      `FPU_CSR_FRM:    exp_csr = {29'd0, model_frm};
      `FPU_CSR_FCSR:   exp_csr = {24'd0, model_frm, model_fflags};
      default: begin
        exp_ready = 1'b0;
        exp_csr   = 32'd0;
      end
    endcase
  endtask

  initial begin
    int         i;
    logic [4:0] r;
    void'($urandom(37));
    reset         = 1'b1;
    instr_valid_i = 1'b0;
    instr_i       = 32'd0;
    int_data_i    = 32'd0;
    csr_wr_i      = '0;
    csr_rden_i    = 1'b0;
    csr_raddr_i   = 12'd0;
    csr_chk       = 1'b0;
    exp_next      = '0;
    ill_next      = 1'b0;
    model_fflags  = 5'd0;
    model_frm     = 3'd0;
    for (i = 0; i < `FPU_NREGS; i++) shadow[i] = 32'd0;
    repeat (5) @(posedge clock);
    @(negedge clock);
    reset = 1'b0;

    test_name = "move_forwarding";
    for (i = 0; i < 10; i++) begin
      r = 5'($urandom);
      issue(OP_FMV_W_X, r, 5'd0, 5'd0, $urandom);
      if (i % 2 == 1) issue(OP_FMV_W_X, r, 5'd0, 5'd0, $urandom);  // Newer write wins
      issue(OP_FMV_X_W, 5'd10, r, 5'd0, 32'd0);  // Distance 1
      issue(OP_FMV_X_W, 5'd11, r, 5'd0, 32'd0);  // Distance 2
      idle(2);
      issue(OP_FMV_X_W, 5'd12, r, 5'd0, 32'd0);  // Distance 5
    end
    idle(3);

    test_name = "sign_injection";
    for (i = 0; i < 8; i++) begin
      issue(OP_FMV_W_X, 5'd1, 5'd0, 5'd0, $urandom);
      issue(OP_FMV_W_X, 5'd2, 5'd0, 5'd0, $urandom);
      issue(OP_FSGNJ, 5'd3, 5'd1, 5'd2, 32'd0);
      issue(OP_FSGNJN, 5'd4, 5'd3, 5'd2, 32'd0);
      issue(OP_FSGNJX, 5'd5, 5'd4, 5'd1, 32'd0);
    end
    idle(3);

    test_name = "csr_access";
    csr_write(`FPU_CSR_FFLAGS, $urandom);
    csr_read(`FPU_CSR_FFLAGS);
    csr_read(`FPU_CSR_FCSR);
    csr_write(`FPU_CSR_FRM, $urandom);
    csr_read(`FPU_CSR_FRM);
    csr_write(`FPU_CSR_FCSR, $urandom);
    csr_read(`FPU_CSR_FFLAGS);
    csr_read(`FPU_CSR_FRM);
    csr_read(`FPU_CSR_FCSR);
    csr_read(12'h7ff);
    csr_write(`FPU_CSR_FFLAGS, 32'd0);

    test_name = "min_max_compare_class";
    for (i = 0; i < 12; i++) begin
      issue(OP_FMV_W_X, 5'd1, 5'd0, 5'd0, special_pairs[i][63:32]);
      issue(OP_FMV_W_X, 5'd2, 5'd0, 5'd0, special_pairs[i][31:0]);
      issue(OP_FMIN, 5'd3, 5'd1, 5'd2, 32'd0);
      issue(OP_FMAX, 5'd4, 5'd1, 5'd2, 32'd0);
      issue(OP_FEQ, 5'd5, 5'd1, 5'd2, 32'd0);
      issue(OP_FLT, 5'd6, 5'd1, 5'd2, 32'd0);
      issue(OP_FLE, 5'd7, 5'd2, 5'd1, 32'd0);
      issue(OP_FCLASS, 5'd8, 5'd1, 5'd0, 32'd0);
      issue(OP_FCLASS, 5'd9, 5'd2, 5'd0, 32'd0);
    end
    idle(3);  // Last accrual lands
    csr_read(`FPU_CSR_FFLAGS);

    test_name = "illegal";
    issue(OP_FMV_W_X, 5'd20, 5'd0, 5'd0, $urandom);
    issue_illegal({7'b0000000, 5'd2, 5'd1, 3'b000, 5'd20, 7'b1010011});  // FADD.S
    issue_illegal({7'b0010000, 5'd2, 5'd1, 3'b000, 5'd20, 7'b1111111});
    issue(OP_FMV_X_W, 5'd13, 5'd20, 5'd0, 32'd0);
    idle(5);

    $display("=== PASS ===");
    $finish;
  end

endmodule

// ==== tb.f ====
+incdir+source
source/fpu_pkg.sv
source/fpu_decode.sv
source/fpu_register.sv
source/fpu_forwarding.sv
source/fpu_csr.sv
source/fpu_execute.sv
source/fpu_top.sv
dv/fpu_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the FPU testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module fpu_tb -f tb.f -o fpu_sim > build.log 2>&1
build_status=$?
if [ $build_status -ne 0 ]; then
  cat build.log
  echo "Verilator build failed with status $build_status"
  exit 1
fi

./obj_dir/fpu_sim > sim.log 2>&1
run_status=$?
cat sim.log

if grep -q "=== FAIL ===" sim.log; then
  exit 1
fi
if [ $run_status -ne 0 ]; then
  echo "Simulation exited with status $run_status"
  exit 1
fi
exit 0
